// ==== source/gamePkg.sv ====
package gamePkg;

    ////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////

    typedef logic [11:0] coordT;    // screen coordinate in pixels
    typedef logic [3:0]  colorT;    // object color index
    typedef logic [3:0]  btnT;      // button vector, one-hot when valid

    ////////////////////////////////////////////////////////////////////
    // button bit positions
    ////////////////////////////////////////////////////////////////////

    localparam int btnUp    = 3;
    localparam int btnDown  = 2;
    localparam int btnRight = 1;
    localparam int btnLeft  = 0;

    ////////////////////////////////////////////////////////////////////
    // playfield and player
    ////////////////////////////////////////////////////////////////////

    // visible area of a 640x480 display
    localparam coordT screenWidth  = 12'd640;
    localparam coordT screenHeight = 12'd480;

    // player is a square sprite
    localparam coordT playerSize = 12'd12;

endpackage

// ==== source/buttonDecoder.sv ====
module buttonDecoder
(
    input  logic         btnClk,
    input  logic         rst,
    input  gamePkg::btnT btns_i,        // raw buttons, already debounced
    input  logic         scrollSel_i,   // 1 scrolls the world, 0 moves the player
    output gamePkg::btnT moveDir_o,     // last accepted direction
    output logic         worldStep_o,   // scroll strobe to both obstacles
    output logic         playerStep_o   // move strobe to the player
);

    gamePkg::btnT btnMeta;      // first sync stage
    gamePkg::btnT btnSync;      // second sync stage
    logic         selMeta;
    logic         selSync;
    logic         oneHot;       // exactly one button down

    // two flops on every async input
    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
        begin
            btnMeta <= '0;
            btnSync <= '0;
            selMeta <= 1'b0;
            selSync <= 1'b0;
        end
        else
        begin
            btnMeta <= btns_i;
            btnSync <= btnMeta;
            selMeta <= scrollSel_i;
            selSync <= selMeta;
        end
    end

    // nonzero and no second bit left once the lowest is cleared
    assign oneHot = (btnSync != '0) && ((btnSync & (btnSync - gamePkg::btnT'(1))) == '0);

    // strobe repeats every cycle while the press holds
    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
        begin
            moveDir_o    <= '0;
            worldStep_o  <= 1'b0;
            playerStep_o <= 1'b0;
        end
        else
        begin
            if (oneHot)
                moveDir_o <= btnSync;   // hold last good direction otherwise
            worldStep_o  <= oneHot && selSync;
            playerStep_o <= oneHot && !selSync;  // never both at once
        end
    end

endmodule

// ==== source/obstacleRect.sv ====
module obstacleRect
#(
    parameter gamePkg::coordT startH    = 12'd0,    // top-left after reset
    parameter gamePkg::coordT startV    = 12'd0,
    parameter gamePkg::coordT objWidth  = 12'd32,
    parameter gamePkg::coordT objHeight = 12'd32,
    parameter gamePkg::colorT rectColor = 4'h1
)
(
    input  logic           btnClk,
    input  logic           rst,
    input  logic           worldStep_i,     // scroll one pixel this cycle
    input  gamePkg::btnT   moveDir_i,       // one-hot scroll direction
    input  logic           visible_i,       // rectangle shown on screen
    input  gamePkg::coordT playerH_i,       // player top-left
    input  gamePkg::coordT playerV_i,
    input  gamePkg::colorT playerColor_i,
    output gamePkg::coordT rectH_o,         // rectangle top-left
    output gamePkg::coordT rectV_o,
    output gamePkg::btnT   blocks_o         // per-side block flags, btnT order
);

    // wrap targets for up and left
    localparam gamePkg::coordT lastH = gamePkg::screenWidth - objWidth;
    localparam gamePkg::coordT lastV = gamePkg::screenHeight - objHeight;

    gamePkg::coordT rectRight;      // first column right of the rectangle
    gamePkg::coordT rectBottom;     // first row below the rectangle
    gamePkg::coordT playerRight;
    gamePkg::coordT playerBottom;
    logic           hOverlap;       // spans share some columns
    logic           vOverlap;       // spans share some rows
    logic           canBlock;
    gamePkg::btnT   blocksNext;

    //////////////////////////////////////////////////////////////////////
    // scrolling
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
        begin
            rectH_o <= startH;
            rectV_o <= startV;
        end
        else if (worldStep_i)
        begin
            if (moveDir_i[gamePkg::btnUp])
            begin
                if (rectV_o == '0)
                    rectV_o <= lastV;       // top edge wraps to bottom
                else
                    rectV_o <= rectV_o - 1'b1;
            end
            else if (moveDir_i[gamePkg::btnDown])
            begin
                // bottom sits on the screen edge, jump to the top
                if (rectBottom >= gamePkg::screenHeight)
                    rectV_o <= '0;
                else
                    rectV_o <= rectV_o + 1'b1;
            end
            else if (moveDir_i[gamePkg::btnRight])
            begin
                if (rectRight >= gamePkg::screenWidth)
                    rectH_o <= '0;          // right edge wraps to left
                else
                    rectH_o <= rectH_o + 1'b1;
            end
            else if (moveDir_i[gamePkg::btnLeft])
            begin
                if (rectH_o == '0)
                    rectH_o <= lastH;
                else
                    rectH_o <= rectH_o - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // contact detection
    //////////////////////////////////////////////////////////////////////

    assign rectRight    = rectH_o + objWidth;
    assign rectBottom   = rectV_o + objHeight;
    assign playerRight  = playerH_i + gamePkg::playerSize;
    assign playerBottom = playerV_i + gamePkg::playerSize;

    // strict overlap, touching corners only does not count
    assign hOverlap = (playerH_i < rectRight) && (playerRight > rectH_o);
    assign vOverlap = (playerV_i < rectBottom) && (playerBottom > rectV_o);

    // same color passes through, hidden rectangle is not there
    assign canBlock = visible_i && (playerColor_i != rectColor);

    always_comb
    begin
        blocksNext = '0;
        // player standing on the rectangle top
        blocksNext[gamePkg::btnDown]  = canBlock && hOverlap && (playerBottom == rectV_o);
        // player just under the rectangle
        blocksNext[gamePkg::btnUp]    = canBlock && hOverlap && (playerV_i == rectBottom);
        // player against the left side
        blocksNext[gamePkg::btnRight] = canBlock && vOverlap && (playerRight == rectH_o);
        // player against the right side
        blocksNext[gamePkg::btnLeft]  = canBlock && vOverlap && (playerH_i == rectRight);
    end

    // flags lag the positions by one edge
    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
            blocks_o <= '0;
        else
            blocks_o <= blocksNext;
    end

endmodule

// ==== source/playerMover.sv ====
module playerMover
#(
    parameter gamePkg::coordT startH = 12'd0,   // player top-left after reset
    parameter gamePkg::coordT startV = 12'd0
)
(
    input  logic           btnClk,
    input  logic           rst,
    input  logic           playerStep_i,    // move one pixel this cycle
    input  gamePkg::btnT   moveDir_i,       // one-hot move direction
    input  gamePkg::btnT   blocks0_i,       // flags from obstacle0
    input  gamePkg::btnT   blocks1_i,       // flags from obstacle1
    output gamePkg::coordT playerH_o,
    output gamePkg::coordT playerV_o,
    output gamePkg::btnT   blocked_o        // union of all block flags
);

    logic canUp;
    logic canDown;
    logic canRight;
    logic canLeft;

    // any obstacle blocking a side blocks it
    assign blocked_o = blocks0_i | blocks1_i;

    //////////////////////////////////////////////////////////////////////
    // per-direction permission
    //////////////////////////////////////////////////////////////////////

    // not blocked and still inside the screen
    assign canUp    = !blocked_o[gamePkg::btnUp] && (playerV_o != '0);
    assign canDown  = !blocked_o[gamePkg::btnDown]
                      && (playerV_o + gamePkg::playerSize < gamePkg::screenHeight);
    assign canRight = !blocked_o[gamePkg::btnRight]
                      && (playerH_o + gamePkg::playerSize < gamePkg::screenWidth);
    assign canLeft  = !blocked_o[gamePkg::btnLeft] && (playerH_o != '0);

    //////////////////////////////////////////////////////////////////////
    // position update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
        begin
            playerH_o <= startH;
            playerV_o <= startV;
        end
        else if (playerStep_i)
        begin
            // refused steps are just dropped
            if (moveDir_i[gamePkg::btnUp] && canUp)
                playerV_o <= playerV_o - 1'b1;
            else if (moveDir_i[gamePkg::btnDown] && canDown)
                playerV_o <= playerV_o + 1'b1;
            else if (moveDir_i[gamePkg::btnRight] && canRight)
                playerH_o <= playerH_o + 1'b1;
            else if (moveDir_i[gamePkg::btnLeft] && canLeft)
                playerH_o <= playerH_o - 1'b1;
        end
    end

endmodule

// ==== source/mazeTop.sv ====
module mazeTop
#(
    // obstacle0, wide and flat
    parameter gamePkg::coordT obs0StartH = 12'd200,
    parameter gamePkg::coordT obs0StartV = 12'd100,
    parameter gamePkg::coordT obs0Width  = 12'd80,
    parameter gamePkg::coordT obs0Height = 12'd40,
    parameter gamePkg::colorT obs0Color  = 4'h2,
    // obstacle1, tall and narrow
    parameter gamePkg::coordT obs1StartH = 12'd400,
    parameter gamePkg::coordT obs1StartV = 12'd300,
    parameter gamePkg::coordT obs1Width  = 12'd40,
    parameter gamePkg::coordT obs1Height = 12'd120,
    parameter gamePkg::colorT obs1Color  = 4'h9,
    // player right edge touches obstacle0 left side
    parameter gamePkg::coordT playerStartH = 12'd188,
    parameter gamePkg::coordT playerStartV = 12'd110
)
(
    input  logic           btnClk,
    input  logic           rst,
    input  gamePkg::btnT   btns_i,
    input  logic           scrollSel_i,
    input  logic           visible_i,
    input  gamePkg::colorT playerColor_i,
    output gamePkg::coordT playerH_o,
    output gamePkg::coordT playerV_o,
    output gamePkg::coordT rect0H_o,
    output gamePkg::coordT rect0V_o,
    output gamePkg::coordT rect1H_o,
    output gamePkg::coordT rect1V_o,
    output gamePkg::btnT   blocked_o
);

    gamePkg::btnT moveDir;      // shared by obstacles and player
    logic         worldStep;
    logic         playerStep;
    gamePkg::btnT blocks0;
    gamePkg::btnT blocks1;

    ////////////////////////////////////////////////////////////////////
    // producer
    ////////////////////////////////////////////////////////////////////

    buttonDecoder decoder
    (
        .btnClk       (btnClk),
        .rst          (rst),
        .btns_i       (btns_i),
        .scrollSel_i  (scrollSel_i),
        .moveDir_o    (moveDir),
        .worldStep_o  (worldStep),
        .playerStep_o (playerStep)
    );

    ////////////////////////////////////////////////////////////////////
    // world state, both rectangles scroll together
    ////////////////////////////////////////////////////////////////////

    obstacleRect #(
        .startH    (obs0StartH),
        .startV    (obs0StartV),
        .objWidth  (obs0Width),
        .objHeight (obs0Height),
        .rectColor (obs0Color)
    ) obstacle0 (
        .btnClk        (btnClk),
        .rst           (rst),
        .worldStep_i   (worldStep),
        .moveDir_i     (moveDir),
        .visible_i     (visible_i),
        .playerH_i     (playerH_o),
        .playerV_i     (playerV_o),
        .playerColor_i (playerColor_i),
        .rectH_o       (rect0H_o),
        .rectV_o       (rect0V_o),
        .blocks_o      (blocks0)
    );

    obstacleRect #(
        .startH    (obs1StartH),
        .startV    (obs1StartV),
        .objWidth  (obs1Width),
        .objHeight (obs1Height),
        .rectColor (obs1Color)
    ) obstacle1 (
        .btnClk        (btnClk),
        .rst           (rst),
        .worldStep_i   (worldStep),
        .moveDir_i     (moveDir),
        .visible_i     (visible_i),
        .playerH_i     (playerH_o),
        .playerV_i     (playerV_o),
        .playerColor_i (playerColor_i),
        .rectH_o       (rect1H_o),
        .rectV_o       (rect1V_o),
        .blocks_o      (blocks1)
    );

    ////////////////////////////////////////////////////////////////////
    // consumer
    ////////////////////////////////////////////////////////////////////

    playerMover #(
        .startH (playerStartH),
        .startV (playerStartV)
    ) mover (
        .btnClk       (btnClk),
        .rst          (rst),
        .playerStep_i (playerStep),
        .moveDir_i    (moveDir),
        .blocks0_i    (blocks0),
        .blocks1_i    (blocks1),
        .playerH_o    (playerH_o),
        .playerV_o    (playerV_o),
        .blocked_o    (blocked_o)
    );

endmodule

// ==== tests/mazeTop_checker.sv ====
module mazeTop_checker
#(
    parameter gamePkg::coordT obs0Width  = 12'd80,  // obstacle0 geometry from the top level
    parameter gamePkg::coordT obs0Height = 12'd40,
    parameter gamePkg::colorT obs0Color  = 4'h2
)
(
    input logic           btnClk,
    input logic           rst,
    input logic           worldStep_i,
    input logic           playerStep_i,
    input gamePkg::btnT   moveDir_i,
    input logic           visible_i,
    input gamePkg::colorT playerColor_i,
    input gamePkg::coordT playerH_i,
    input gamePkg::coordT playerV_i,
    input gamePkg::coordT rect0H_i,
    input gamePkg::coordT rect0V_i,
    input gamePkg::btnT   blocked_i,
    input gamePkg::btnT   blocks0_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;      // failed assertions so far

    function automatic void countFailure(input string msg);
        failCount++;
        $error("%s", msg);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // player moves and refused steps
    //////////////////////////////////////////////////////////////////////

    moveRight: assert property (@(posedge btnClk) disable iff (rst)
        playerStep_i && moveDir_i[gamePkg::btnRight] && !blocked_i[gamePkg::btnRight]
        && (playerH_i + 12'd12 < 12'd640) |=> playerH_i == $past(playerH_i) + 12'd1)
        else countFailure("player did not step right");
    refuseRight: assert property (@(posedge btnClk) disable iff (rst)
        playerStep_i && moveDir_i[gamePkg::btnRight] && blocked_i[gamePkg::btnRight]
        |=> $stable(playerH_i) && $stable(playerV_i))
        else countFailure("blocked player moved right");
    moveUp: assert property (@(posedge btnClk) disable iff (rst)
        playerStep_i && moveDir_i[gamePkg::btnUp] && !blocked_i[gamePkg::btnUp]
        && (playerV_i != 12'd0) |=> playerV_i == $past(playerV_i) - 12'd1)
        else countFailure("player did not step up");
    clampUp: assert property (@(posedge btnClk) disable iff (rst)
        playerStep_i && moveDir_i[gamePkg::btnUp] && (playerV_i == 12'd0) |=> playerV_i == 12'd0)
        else countFailure("player left the top edge");
    // world and player never both move
    playerStill: assert property (@(posedge btnClk) disable iff (rst)
        !playerStep_i |=> $stable(playerH_i) && $stable(playerV_i))
        else countFailure("player moved without a strobe");
    rectStill: assert property (@(posedge btnClk) disable iff (rst)
        !worldStep_i |=> $stable(rect0H_i) && $stable(rect0V_i))
        else countFailure("rectangle moved without a strobe");

    //////////////////////////////////////////////////////////////////////
    // scrolling with wrap
    //////////////////////////////////////////////////////////////////////

    scrollLeft: assert property (@(posedge btnClk) disable iff (rst)
        worldStep_i && moveDir_i[gamePkg::btnLeft] |=> rect0H_i ==
        (($past(rect0H_i) == 12'd0) ? 12'd640 - obs0Width : $past(rect0H_i) - 12'd1))
        else countFailure("rectangle left scroll wrong");
    scrollUp: assert property (@(posedge btnClk) disable iff (rst)
        worldStep_i && moveDir_i[gamePkg::btnUp] |=> rect0V_i ==
        (($past(rect0V_i) == 12'd0) ? 12'd480 - obs0Height : $past(rect0V_i) - 12'd1))
        else countFailure("rectangle up scroll wrong");

    //////////////////////////////////////////////////////////////////////
    // blocking flags
    //////////////////////////////////////////////////////////////////////

    // right side contact with strict vertical overlap
    flagRight: assert property (@(posedge btnClk) disable iff (rst)
        visible_i && (playerColor_i != obs0Color) && (playerH_i + 12'd12 == rect0H_i)
        && (playerV_i < rect0V_i + obs0Height) && (playerV_i + 12'd12 > rect0V_i)
        |=> blocks0_i[gamePkg::btnRight])
        else countFailure("right block flag missing");
    noFlagHidden: assert property (@(posedge btnClk) disable iff (rst)
        !visible_i |=> blocked_i == 4'b0000)
        else countFailure("hidden rectangle raised a flag");
    noFlagColor: assert property (@(posedge btnClk) disable iff (rst)
        playerColor_i == obs0Color |=> blocks0_i == 4'b0000)
        else countFailure("same color rectangle raised a flag");

endmodule

bind mazeTop mazeTop_checker #(
    .obs0Width  (obs0Width),
    .obs0Height (obs0Height),
    .obs0Color  (obs0Color)
) checker0
(
    .btnClk        (btnClk),
    .rst           (rst),
    .worldStep_i   (worldStep),
    .playerStep_i  (playerStep),
    .moveDir_i     (moveDir),
    .visible_i     (visible_i),
    .playerColor_i (playerColor_i),
    .playerH_i     (playerH_o),
    .playerV_i     (playerV_o),
    .rect0H_i      (rect0H_o),
    .rect0V_i      (rect0V_o),
    .blocked_i     (blocked_o),
    .blocks0_i     (blocks0)
);

// ==== tests/mazeTop_tb.sv ====
module mazeTop_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic           btnClk;
    logic           rst;
    gamePkg::btnT   btns;
    logic           scrollSel;
    logic           visible;
    gamePkg::colorT playerColor;
    gamePkg::coordT playerH;
    gamePkg::coordT playerV;
    gamePkg::coordT rect0H;
    gamePkg::coordT rect0V;
    gamePkg::coordT rect1H;
    gamePkg::coordT rect1V;
    gamePkg::btnT   blocked;

    logic [31:0] rngState = 32'h52305094;
    int          errors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          errsBefore;

    mazeTop UUT
    (
        .btnClk (btnClk), .rst (rst), .btns_i (btns), .scrollSel_i (scrollSel),
        .visible_i (visible), .playerColor_i (playerColor),
        .playerH_o (playerH), .playerV_o (playerV), .rect0H_o (rect0H), .rect0V_o (rect0V),
        .rect1H_o (rect1H), .rect1V_o (rect1V), .blocked_o (blocked)
    );

    initial
    begin
        btnClk = 1'b0;
        forever #20 btnClk = ~btnClk;   // 40 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // compare errors plus failed assertions in the bound checker
    function automatic int errorTotal();
        return errors + UUT.checker0.failCount;
    endfunction

    task automatic afterEdge();
        @(posedge btnClk);
        #2;
    endtask

    task automatic compareCoord(input string name, input logic [11:0] got, input logic [11:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s got 0x%03h expected 0x%03h", name, got, exp);
            errors++;
        end
    endtask

    // hold a vector for n edges, then release and let the pipeline drain
    task automatic holdButtons(input gamePkg::btnT vec, input int n);
        afterEdge();
        btns = vec;
        repeat (n) afterEdge();
        btns = 4'b0000;
        repeat (5) afterEdge();
    endtask

    // bounded wait for a given blocked_o bit
    task automatic waitFlag(input int bitIdx);
        int i;
        for (i = 0; i < 20 && !blocked[bitIdx]; i++)
            afterEdge();
        if (!blocked[bitIdx])
        begin
            $display("timeout waiting for block flag %0d", bitIdx);
            errors++;
        end
    endtask

    task automatic finishTest(input string name);
        int total;
        total = errorTotal();
        testsRun++;
        if (total != errsBefore)
            testsFailed++;
        $display("test %s: %s", name, (total == errsBefore) ? "ok" : "failed");
        errsBefore = total;
    endtask

    initial
    begin
        int k;
        int hold;
        gamePkg::btnT vec;
        gamePkg::coordT snap [6];
        btns = 4'b0000;
        scrollSel = 1'b0;
        visible = 1'b1;
        playerColor = 4'h5;
        rst = 1'b1;
        errsBefore = 0;
        repeat (4) afterEdge();
        // start values straight from the top level defaults
        compareCoord("playerH_o", playerH, 12'd188);
        compareCoord("playerV_o", playerV, 12'd110);
        compareCoord("rect0H_o", rect0H, 12'd200);
        compareCoord("rect0V_o", rect0V, 12'd100);
        compareCoord("rect1H_o", rect1H, 12'd400);
        compareCoord("rect1V_o", rect1V, 12'd300);
        compareCoord("blocked_o", {8'h0, blocked}, 12'h000);
        rst = 1'b0;
        finishTest("reset");

        waitFlag(gamePkg::btnRight);     // player starts against obstacle0
        holdButtons(4'b0010, 6);
        compareCoord("playerH_o", playerH, 12'd188);
        finishTest("block right");

        // player still against obstacle0
        visible = 1'b0;
        repeat (4) afterEdge();
        compareCoord("blocked_o", {8'h0, blocked}, 12'h000);
        playerColor = 4'h2;
        visible = 1'b1;
        repeat (4) afterEdge();
        compareCoord("blocked_o", {8'h0, blocked}, 12'h000);
        playerColor = 4'h5;
        waitFlag(gamePkg::btnRight);
        finishTest("no block");

        rngState = xorshift32(rngState);
        hold = 4 + int'(rngState % 32'd8);
        holdButtons(4'b0001, hold);     // left, away from the rectangle
        compareCoord("playerH_o", playerH, 12'd188 - 12'(hold));
        holdButtons(4'b1000, 120);      // up into the top edge clamp
        compareCoord("playerV_o", playerV, 12'd0);
        holdButtons(4'b0010, 3);        // short step right, clear of obstacle0
        compareCoord("playerH_o", playerH, 12'd191 - 12'(hold));
        compareCoord("rect0H_o", rect0H, 12'd200);
        compareCoord("rect0V_o", rect0V, 12'd100);
        compareCoord("rect1H_o", rect1H, 12'd400);
        compareCoord("rect1V_o", rect1V, 12'd300);
        finishTest("player move");

        scrollSel = 1'b1;
        holdButtons(4'b0001, 210);      // wraps obstacle0 left edge
        holdButtons(4'b1000, 110);      // wraps obstacle0 top edge
        compareCoord("rect0H_o", rect0H, 12'd551);
        compareCoord("rect0V_o", rect0V, 12'd431);
        compareCoord("rect1H_o", rect1H, 12'd190);
        compareCoord("rect1V_o", rect1V, 12'd190);
        holdButtons(4'b0010, 10);       // obstacle0 right edge reaches 640 and wraps
        holdButtons(4'b0100, 10);       // bottom edge reaches 480 and wraps
        compareCoord("rect0H_o", rect0H, 12'd0);
        compareCoord("rect0V_o", rect0V, 12'd0);
        compareCoord("rect1H_o", rect1H, 12'd200);
        compareCoord("rect1V_o", rect1V, 12'd200);
        compareCoord("playerV_o", playerV, 12'd0);
        scrollSel = 1'b0;
        finishTest("scroll");

        for (k = 0; k < 12; k++)
        begin
            rngState = xorshift32(rngState);
            vec = rngState[3:0];
            if ($countones(vec) == 1)
                vec = vec | 4'b0011;    // never one-hot
            snap = '{playerH, playerV, rect0H, rect0V, rect1H, rect1V};
            holdButtons(vec, 3 + int'(rngState[6:4]));
            compareCoord("playerH_o", playerH, snap[0]);
            compareCoord("playerV_o", playerV, snap[1]);
            compareCoord("rect0H_o", rect0H, snap[2]);
            compareCoord("rect0V_o", rect0V, snap[3]);
            compareCoord("rect1H_o", rect1H, snap[4]);
            compareCoord("rect1V_o", rect1V, snap[5]);
        end
        finishTest("invalid buttons");

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorTotal());
        if (errorTotal() == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== mazeTop.f ====
source/gamePkg.sv
source/buttonDecoder.sv
source/obstacleRect.sv
source/playerMover.sv
source/mazeTop.sv
tests/mazeTop_checker.sv
tests/mazeTop_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mazeTop_tb
FLIST     ?= mazeTop.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0

SRCS := $(wildcard source/*.sv) $(wildcard tests/*.sv)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
